// ==== Makefile ====
# Verilator build and run of the traffic generator testbench
TOP := tb_tgen_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run all trace tests"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tgen.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "Result: FAIL"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || { echo "Result: FAIL, no verdict in log"; exit 1; }
	@echo "Result: PASS"

clean:
	rm -rf obj_dir sim.log

// ==== common/tcdm_if.sv ====
// One TCDM port, full-word read request with reorder ID and its response
// Requester takes master, memory side slave, observers the monitor modport
`default_nettype none

interface tcdm_if;
  import tgen_pkg::*;

  logic                  req_valid;
  logic                  req_ready;
  logic [addr_width-1:0] req_addr;
  logic [id_width-1:0]   req_id;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [data_width-1:0] resp_rdata;
  logic [id_width-1:0]   resp_id;

  modport master (
    output req_valid, req_addr, req_id, resp_ready,
    input  req_ready, resp_valid, resp_rdata, resp_id
  );
  modport slave (
    input  req_valid, req_addr, req_id, resp_ready,
    output req_ready, resp_valid, resp_rdata, resp_id
  );
  modport monitor (
    input req_valid, req_ready, req_addr, req_id,
    input resp_valid, resp_ready, resp_rdata, resp_id
  );

endinterface

`default_nettype wire

// ==== common/tgen_pkg.sv ====
// Shared constants, state enum and TCDM address map of the traffic generator
// Import inside module bodies, use scoped names in port lists
`default_nettype none

package tgen_pkg;

  // Word and port sizes
  localparam int unsigned addr_width     = 32;
  localparam int unsigned data_width     = 32;
  localparam int unsigned num_tcdm       = 2;
  localparam int unsigned port_idx_width = $clog2(num_tcdm);
  localparam int unsigned stat_width     = 32;

  // Reorder IDs
  localparam int unsigned max_outstanding = 16;
  localparam int unsigned id_width        = $clog2(max_outstanding);

  // Cluster geometry
  localparam int unsigned num_cores      = 16;
  localparam int unsigned core_id_width  = $clog2(num_cores);
  localparam int unsigned num_tiles      = 4;
  localparam int unsigned tile_width     = $clog2(num_tiles);
  localparam int unsigned banks_per_tile = 4;
  localparam int unsigned byte_offset    = 2;
  // Tile field sits right above the bank select bits
  localparam int unsigned tile_lsb       = byte_offset + $clog2(banks_per_tile);

  // TCDM window, size is a power of two
  localparam logic [addr_width-1:0] tcdm_base        = 32'h0000_0000;
  localparam logic [addr_width-1:0] tcdm_size        = 32'h0001_0000;
  localparam logic [addr_width-1:0] tcdm_offset_mask = tcdm_size - 1;

  // Used whenever the seed input is zero, xorshift locks up on zero
  localparam logic [31:0] rng_default_seed = 32'h2545_f491;

  typedef enum logic [1:0] {tgen_idle, tgen_run, tgen_drain, tgen_done} tgen_state_e;

  typedef struct packed {
    logic [addr_width-1:0]     start_addr;
    logic [addr_width-1:0]     end_addr;    // exclusive
    logic [port_idx_width-1:0] port_idx;
  } rule_t;

  // Lower half to port 0, upper half to port 1
  localparam int unsigned num_rules = 2;
  localparam rule_t addr_map [num_rules] = '{
    '{start_addr: 32'h0000_0000, end_addr: 32'h0000_8000, port_idx: 0},
    '{start_addr: 32'h0000_8000, end_addr: 32'h0001_0000, port_idx: 1}
  };

endpackage

`default_nettype wire

// ==== rtl/addr_demux.sv ====
// Steers core requests to a TCDM port by the address map
// and merges the port responses back one per cycle with port 0 first
`default_nettype none

module addr_demux (
  input  logic   clk_i,
  input  logic   rst_n_i,
  tcdm_if.slave  core_port,
  tcdm_if.master mem_port [tgen_pkg::num_tcdm]
);
  import tgen_pkg::*;

  logic [port_idx_width-1:0] sel;
  logic [num_tcdm-1:0]       req_ready_vec;
  logic [num_tcdm-1:0]       resp_valid_vec;
  logic [num_tcdm-1:0]       resp_gnt;
  logic [num_tcdm-1:0]       resp_fire_vec;
  logic [data_width-1:0]     resp_rdata_vec [num_tcdm];
  logic [id_width-1:0]       resp_id_vec [num_tcdm];

  // A miss falls through to port 0
  always_comb begin
    sel = '0;
    for (int r = 0; r < num_rules; r++) begin
      if (core_port.req_addr >= addr_map[r].start_addr &&
          core_port.req_addr < addr_map[r].end_addr) begin
        sel = addr_map[r].port_idx;
      end
    end
  end

  // Lowest valid port wins
  assign resp_gnt = resp_valid_vec & ~(resp_valid_vec - 1'b1);

  for (genvar p = 0; p < num_tcdm; p++) begin : gen_port
    assign mem_port[p].req_valid  = core_port.req_valid && (sel == port_idx_width'(p));
    assign mem_port[p].req_addr   = core_port.req_addr;
    assign mem_port[p].req_id     = core_port.req_id;
    // An idle port sees ready high and only a losing port is held off
    assign mem_port[p].resp_ready = core_port.resp_ready &&
                                    (resp_gnt[p] || !mem_port[p].resp_valid);
    assign req_ready_vec[p]  = mem_port[p].req_ready;
    assign resp_valid_vec[p] = mem_port[p].resp_valid;
    assign resp_rdata_vec[p] = mem_port[p].resp_rdata;
    assign resp_id_vec[p]    = mem_port[p].resp_id;
    assign resp_fire_vec[p]  = mem_port[p].resp_valid && mem_port[p].resp_ready;
  end

  assign core_port.req_ready = req_ready_vec[sel];

  always_comb begin
    core_port.resp_valid = |resp_valid_vec;
    core_port.resp_rdata = '0;
    core_port.resp_id    = '0;
    for (int p = 0; p < num_tcdm; p++) begin
      if (resp_gnt[p]) begin
        core_port.resp_rdata = resp_rdata_vec[p];
        core_port.resp_id    = resp_id_vec[p];
      end
    end
  end

  one_resp_per_cycle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(resp_fire_vec));

endmodule

`default_nettype wire

// ==== rtl/latency_monitor.sv ====
// Watches the core port, stamps each ID at request transfer
// and keeps request, response, latency sum and latency maximum counters
`default_nettype none

module latency_monitor (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            clear_i,
  tcdm_if.monitor                         core_port,
  output logic                            release_o,
  output logic [tgen_pkg::id_width-1:0]   release_id_o,
  output logic [tgen_pkg::stat_width-1:0] issued_o,
  output logic [tgen_pkg::stat_width-1:0] completed_o,
  output logic [tgen_pkg::stat_width-1:0] lat_sum_o,
  output logic [tgen_pkg::stat_width-1:0] lat_max_o
);
  import tgen_pkg::*;

  logic [stat_width-1:0] cycle_q;
  logic [stat_width-1:0] stamp_q [max_outstanding];
  logic [stat_width-1:0] latency;
  logic                  req_fire;
  logic                  resp_fire;

  assign req_fire  = core_port.req_valid && core_port.req_ready;
  assign resp_fire = core_port.resp_valid && core_port.resp_ready;
  assign latency   = cycle_q - stamp_q[core_port.resp_id];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) stamp_q[core_port.req_id] <= cycle_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      issued_o    <= '0;
      completed_o <= '0;
      lat_sum_o   <= '0;
      lat_max_o   <= '0;
    end else begin
      if (req_fire) issued_o <= issued_o + 1'b1;
      if (resp_fire) begin
        completed_o <= completed_o + 1'b1;
        lat_sum_o   <= lat_sum_o + latency;
        if (latency > lat_max_o) lat_max_o <= latency;
      end
    end
  end

  // Completion frees the ID in the allocator
  assign release_o    = resp_fire;
  assign release_id_o = core_port.resp_id;

endmodule

`default_nettype wire

// ==== rtl/tgen_top.sv ====
// Traffic generator top with flat TCDM pins, one core's load source
// Pulse start_i with the run settings, wait for done_o, read the statistics
`default_nettype none

module tgen_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  start_i,
  input  logic [31:0]                                           seed_i,
  input  logic [31:0]                                           num_cycles_i,
  input  logic [9:0]                                            req_prob_i,
  input  logic [9:0]                                            seq_prob_i,
  input  logic [tgen_pkg::core_id_width-1:0]                    core_id_i,
  output logic [tgen_pkg::num_tcdm-1:0]                         tcdm_req_valid_o,
  output logic [tgen_pkg::num_tcdm-1:0][tgen_pkg::addr_width-1:0] tcdm_req_addr_o,
  output logic [tgen_pkg::num_tcdm-1:0][tgen_pkg::id_width-1:0] tcdm_req_id_o,
  input  logic [tgen_pkg::num_tcdm-1:0]                         tcdm_req_ready_i,
  input  logic [tgen_pkg::num_tcdm-1:0]                         tcdm_resp_valid_i,
  output logic [tgen_pkg::num_tcdm-1:0]                         tcdm_resp_ready_o,
  input  logic [tgen_pkg::num_tcdm-1:0][tgen_pkg::data_width-1:0] tcdm_resp_rdata_i,
  input  logic [tgen_pkg::num_tcdm-1:0][tgen_pkg::id_width-1:0] tcdm_resp_id_i,
  output logic                                                  done_o,
  output logic [tgen_pkg::stat_width-1:0]                       issued_o,
  output logic [tgen_pkg::stat_width-1:0]                       completed_o,
  output logic [tgen_pkg::stat_width-1:0]                       lat_sum_o,
  output logic [tgen_pkg::stat_width-1:0]                       lat_max_o
);
  import tgen_pkg::*;

  logic [id_width-1:0] next_id;
  logic [id_width-1:0] freed_id;
  logic                full;
  logic                idle;
  logic                alloc;
  logic                id_free;

  tcdm_if core_port ();
  tcdm_if mem_port [num_tcdm] ();

  traffic_gen i_traffic_gen (
    .clk_i, .rst_n_i, .start_i, .seed_i, .num_cycles_i, .req_prob_i, .seq_prob_i,
    .core_id_i, .next_id_i(next_id), .full_i(full), .idle_i(idle),
    .alloc_o(alloc), .done_o, .core_port(core_port)
  );

  // Start also wipes the pending IDs and the statistics
  rob_id_alloc i_rob_id_alloc (
    .clk_i, .rst_n_i, .clear_i(start_i), .alloc_i(alloc), .release_i(id_free),
    .release_id_i(freed_id), .next_id_o(next_id), .full_o(full), .idle_o(idle)
  );

  addr_demux i_addr_demux (.clk_i, .rst_n_i, .core_port(core_port), .mem_port(mem_port));

  latency_monitor i_latency_monitor (
    .clk_i, .rst_n_i, .clear_i(start_i), .core_port(core_port),
    .release_o(id_free), .release_id_o(freed_id),
    .issued_o, .completed_o, .lat_sum_o, .lat_max_o
  );

  for (genvar p = 0; p < num_tcdm; p++) begin : gen_mem_pins
    assign tcdm_req_valid_o[p]    = mem_port[p].req_valid;
    assign tcdm_req_addr_o[p]     = mem_port[p].req_addr;
    assign tcdm_req_id_o[p]       = mem_port[p].req_id;
    assign tcdm_resp_ready_o[p]   = mem_port[p].resp_ready;
    assign mem_port[p].req_ready  = tcdm_req_ready_i[p];
    assign mem_port[p].resp_valid = tcdm_resp_valid_i[p];
    assign mem_port[p].resp_rdata = tcdm_resp_rdata_i[p];
    assign mem_port[p].resp_id    = tcdm_resp_id_i[p];
  end

endmodule

`default_nettype wire

// ==== testbench/tb_tgen_top.sv ====
// Trace-driven testbench of the traffic generator top with one run per trace line
// Models both TCDM ports and checks routing, IDs, tile locality and statistics
`default_nettype none

module tb_tgen_top;
  timeunit 1ns;
  timeprecision 1ps;
  import tgen_pkg::*;

  logic clk;
  logic rst_n;
  logic start;
  logic [31:0] seed;
  logic [31:0] num_cycles;
  logic [9:0] req_prob;
  logic [9:0] seq_prob;
  logic [core_id_width-1:0] core_id;
  logic [num_tcdm-1:0] req_valid;
  logic [num_tcdm-1:0][addr_width-1:0] req_addr;
  logic [num_tcdm-1:0][id_width-1:0] req_id;
  logic [num_tcdm-1:0] req_ready;
  logic [num_tcdm-1:0] resp_valid;
  logic [num_tcdm-1:0] resp_ready;
  logic [num_tcdm-1:0][data_width-1:0] resp_rdata;
  logic [num_tcdm-1:0][id_width-1:0] resp_id;
  logic done;
  logic [stat_width-1:0] issued;
  logic [stat_width-1:0] completed;
  logic [stat_width-1:0] lat_sum;
  logic [stat_width-1:0] lat_max;

  // Trace columns
  string t_name[$];
  logic [31:0] t_seed[$];
  int t_cycles[$];
  int t_req[$];
  int t_seq[$];
  int t_core[$];
  int t_lat[$];
  int t_ready[$];

  // Scoreboard and port models
  string cur_test;
  int cur_lat;
  int cur_ready;
  logic [31:0] rng;
  int unsigned cyc;
  int unsigned n_issued;
  int unsigned n_done;
  int unsigned sum_lat;
  int unsigned max_lat;
  int outstanding;
  bit pending [max_outstanding];
  int unsigned accept_cyc [max_outstanding];
  int unsigned due_q [num_tcdm][$];
  logic [addr_width-1:0] addr_q [num_tcdm][$];
  logic [id_width-1:0] id_q [num_tcdm][$];
  longint unsigned limit_ns;

  tgen_top dut_i (
    .clk_i(clk), .rst_n_i(rst_n), .start_i(start), .seed_i(seed),
    .num_cycles_i(num_cycles), .req_prob_i(req_prob), .seq_prob_i(seq_prob),
    .core_id_i(core_id), .tcdm_req_valid_o(req_valid), .tcdm_req_addr_o(req_addr),
    .tcdm_req_id_o(req_id), .tcdm_req_ready_i(req_ready), .tcdm_resp_valid_i(resp_valid),
    .tcdm_resp_ready_o(resp_ready), .tcdm_resp_rdata_i(resp_rdata),
    .tcdm_resp_id_i(resp_id), .done_o(done), .issued_o(issued), .completed_o(completed),
    .lat_sum_o(lat_sum), .lat_max_o(lat_max)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // New ready pattern each falling edge and the head response once it is due
  task automatic drive_ports();
    cyc++;
    for (int p = 0; p < num_tcdm; p++) begin
      rng = next_rand(rng);
      req_ready[p] = (rng % 32'd100) < 32'(cur_ready);
      resp_valid[p] = due_q[p].size() > 0 && due_q[p][0] <= cyc;
      resp_rdata[p] = resp_valid[p] ? addr_q[p][0] : '0;
      resp_id[p] = resp_valid[p] ? id_q[p][0] : '0;
    end
  endtask

  // Handshakes sampled late in the cycle transfer at the next rising edge
  task automatic sample_ports();
    logic [addr_width-1:0] a;
    int unsigned lat;
    for (int p = 0; p < num_tcdm; p++) begin
      if (resp_valid[p]) begin
        check_value("resp_ready", (p == 0 || !resp_valid[0]) ? 1 : 0, resp_ready[p]);
      end
      if (resp_valid[p] && resp_ready[p]) begin
        lat = cyc - accept_cyc[resp_id[p]];
        sum_lat += lat;
        if (lat > max_lat) max_lat = lat;
        n_done++;
        pending[resp_id[p]] = 0;
        outstanding--;
        void'(due_q[p].pop_front());
        void'(addr_q[p].pop_front());
        void'(id_q[p].pop_front());
      end
    end
    for (int p = 0; p < num_tcdm; p++) begin
      if (req_valid[p]) begin
        a = req_addr[p];
        // Lower half of the window goes to port 0 and the upper half to port 1
        check_value("port", (a - tcdm_base) >= (tcdm_size >> 1) ? 1 : 0, p);
        check_value("word_align", 0, a[byte_offset-1:0]);
        check_value("in_window", 1, (a - tcdm_base) < tcdm_size);
        if (seq_prob == 10'd1000) begin
          check_value("tile", core_id[core_id_width-1 -: tile_width],
                      a[tile_lsb +: tile_width]);
        end
        if (req_ready[p]) begin
          check_value("outstanding_bound", 1, outstanding < max_outstanding);
          check_value("id_free", 0, pending[req_id[p]]);
          pending[req_id[p]] = 1;
          accept_cyc[req_id[p]] = cyc;
          outstanding++;
          n_issued++;
          rng = next_rand(rng);
          // Small random spread on top of the line's latency lets responses collide
          due_q[p].push_back(cyc + cur_lat + (rng % 32'd4));
          addr_q[p].push_back(a);
          id_q[p].push_back(req_id[p]);
        end
      end
    end
    if (done) check_value("outstanding_at_done", 0, outstanding);
  endtask

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("Timeout: done_o did not rise in time, generator state %s",
             dut_i.i_traffic_gen.state_q.name());
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int fd;
    int n;
    string line;
    string name;
    logic [31:0] s;
    int c;
    int rq;
    int sq;
    int co;
    int la;
    int rd;
    longint unsigned total;
    clk = 0;
    rst_n = 0;
    start = 0;
    seed = '0;
    num_cycles = '0;
    req_prob = '0;
    seq_prob = '0;
    core_id = '0;
    req_ready = '0;
    resp_valid = '0;
    resp_rdata = '0;
    resp_id = '0;
    rng = 32'ha383_843a;
    cyc = 0;
    cur_lat = 1;
    cur_ready = 100;
    limit_ns = 0;
    total = 1000;
    fd = $fopen("testbench/tgen_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file testbench/tgen_trace.txt");
      $display("Simulation FAILED");
      $fatal(1, "no trace");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %d %d %d %d %d %d", name, s, c, rq, sq, co, la, rd);
        if (n == 8) begin
          t_name.push_back(name);
          t_seed.push_back(s);
          t_cycles.push_back(c);
          t_req.push_back(rq);
          t_seq.push_back(sq);
          t_core.push_back(co);
          t_lat.push_back(la);
          t_ready.push_back(rd);
          total += longint'(c + 200) * 100;
        end
      end
    end
    $fclose(fd);
    limit_ns = total;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1;
    cur_test = "reset";
    #40;
    check_value("done_after_reset", 0, done);
    check_value("req_valid_after_reset", 0, req_valid);
    check_value("resp_ready_after_reset", {num_tcdm{1'b1}}, resp_ready);
    foreach (t_name[i]) begin
      cur_test = t_name[i];
      cur_lat = t_lat[i];
      cur_ready = t_ready[i];
      n_issued = 0;
      n_done = 0;
      sum_lat = 0;
      max_lat = 0;
      outstanding = 0;
      foreach (pending[k]) pending[k] = 0;
      @(negedge clk);
      seed = t_seed[i];
      num_cycles = t_cycles[i];
      req_prob = 10'(t_req[i]);
      seq_prob = 10'(t_seq[i]);
      core_id = core_id_width'(t_core[i]);
      start = 1;
      drive_ports();
      #40;
      sample_ports();
      do begin
        @(negedge clk);
        start = 0;
        drive_ports();
        #40;
        sample_ports();
      end while (!done);
      if (t_req[i] == 0) check_value("no_requests", 0, n_issued);
      check_value("issued", n_issued, issued);
      check_value("completed", n_done, completed);
      check_value("lat_sum", sum_lat, lat_sum);
      check_value("lat_max", max_lat, lat_max);
      $display("%s: %0d requests, latency sum %0d, max %0d", cur_test, n_issued, sum_lat,
               max_lat);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tgen_trace.txt ====
# name seed(hex) num_cycles req_prob seq_prob core_id mem_latency ready_pct
# req_prob and seq_prob in thousandths, mem_latency in cycles, ready_pct in percent
mixed       1234abcd 300  500  300  5  3  80
local_tile  0badf00d 200  700 1000 14  2 100
no_traffic  00000042 150    0  500  3  4 100
id_fill     5a5a5a5a 120 1000    0  9 80 100
slow_ready  deadbeef 250  900  100  7  6  30
zero_seed   00000000  80  600  600 12  1  50
back2back   cafe0001 300 1000    0  0  1 100

// ==== tgen.f ====
common/tgen_pkg.sv
common/tcdm_if.sv
traffic_gen/rob_id_alloc.sv
traffic_gen/traffic_gen.sv
rtl/addr_demux.sv
rtl/latency_monitor.sv
rtl/tgen_top.sv
testbench/tb_tgen_top.sv

// ==== traffic_gen/rob_id_alloc.sv ====
// Reorder ID allocator, one pending bit per ID
// Hands out the lowest free ID and frees IDs on completion
`default_nettype none

module rob_id_alloc (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          alloc_i,
  input  logic                          release_i,
  input  logic [tgen_pkg::id_width-1:0] release_id_i,
  output logic [tgen_pkg::id_width-1:0] next_id_o,
  output logic                          full_o,
  output logic                          idle_o
);
  import tgen_pkg::*;

  logic [max_outstanding-1:0] pending_q;
  logic [max_outstanding-1:0] free_vec;

  assign free_vec = ~pending_q;

  // Scan from the top so the lowest free bit is the last to hit
  always_comb begin
    next_id_o = '0;
    for (int i = max_outstanding - 1; i >= 0; i--) begin
      if (free_vec[i]) next_id_o = id_width'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      pending_q <= '0;
    end else begin
      if (alloc_i) pending_q[next_id_o] <= 1'b1;
      if (release_i) pending_q[release_id_i] <= 1'b0;
    end
  end

  assign full_o = &pending_q;
  assign idle_o = ~|pending_q;

  release_pending_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    release_i |-> pending_q[release_id_i]);

  // The engine must respect the full flag
  no_alloc_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_i |-> !full_o);

endmodule

`default_nettype wire

// ==== traffic_gen/traffic_gen.sv ====
// Issue engine of the load generator that runs num_cycles_i creation cycles per start
// Creates random full-word reads and presents them one at a time on core_port
`default_nettype none

module traffic_gen (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  logic [31:0]                        seed_i,
  input  logic [31:0]                        num_cycles_i,
  input  logic [9:0]                         req_prob_i,
  input  logic [9:0]                         seq_prob_i,
  input  logic [tgen_pkg::core_id_width-1:0] core_id_i,
  input  logic [tgen_pkg::id_width-1:0]      next_id_i,
  input  logic                               full_i,
  input  logic                               idle_i,
  output logic                               alloc_o,
  output logic                               done_o,
  tcdm_if.master                             core_port
);
  import tgen_pkg::*;

  tgen_state_e           state_q;
  logic [31:0]           rng_q;
  logic [31:0]           draw_req;
  logic [31:0]           draw_addr;
  logic [31:0]           draw_seq;
  logic [31:0]           run_cnt_q;
  logic                  q_valid_q;
  logic [addr_width-1:0] q_addr_q;
  logic [id_width-1:0]   q_id_q;
  logic [addr_width-1:0] new_addr;
  logic                  create;
  logic                  req_fire;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Scale the upper half-word onto 0..999
  function automatic logic [9:0] per_mille(input logic [31:0] x);
    logic [25:0] prod;
    prod = x[31:16] * 10'd1000;
    return prod[25:16];
  endfunction

  // Three chained steps per cycle give three independent draws
  assign draw_req  = xorshift32(rng_q);
  assign draw_addr = xorshift32(draw_req);
  assign draw_seq  = xorshift32(draw_addr);

  always_comb begin
    new_addr = tcdm_base | (draw_addr & tcdm_offset_mask);
    new_addr[byte_offset-1:0] = '0;
    // Pull the access into the own tile
    if (per_mille(draw_seq) < seq_prob_i) begin
      new_addr[tile_lsb +: tile_width] = core_id_i[core_id_width-1 -: tile_width];
    end
  end

  assign create = (state_q == tgen_run) && !q_valid_q && !full_i &&
                  (per_mille(draw_req) < req_prob_i);
  assign req_fire = core_port.req_valid && core_port.req_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= tgen_idle;
      rng_q     <= rng_default_seed;
      run_cnt_q <= '0;
    end else begin
      rng_q <= draw_seq;
      case (state_q)
        tgen_idle, tgen_done: begin
          if (start_i) begin
            rng_q     <= (seed_i != '0) ? seed_i : rng_default_seed;
            run_cnt_q <= '0;
            state_q   <= (num_cycles_i == '0) ? tgen_drain : tgen_run;
          end
        end
        tgen_run: begin
          run_cnt_q <= run_cnt_q + 32'd1;
          if (run_cnt_q == num_cycles_i - 32'd1) state_q <= tgen_drain;
        end
        // Wait for the queue and all outstanding IDs
        tgen_drain: if (!q_valid_q && idle_i) state_q <= tgen_done;
        default: state_q <= tgen_idle;
      endcase
    end
  end

  // Single-entry request queue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      q_valid_q <= 1'b0;
    end else if (create) begin
      q_valid_q <= 1'b1;
    end else if (req_fire) begin
      q_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (create) begin
      q_addr_q <= new_addr;
      q_id_q   <= next_id_i;
    end
  end

  assign core_port.req_valid  = q_valid_q;
  assign core_port.req_addr   = q_addr_q;
  assign core_port.req_id     = q_id_q;
  assign core_port.resp_ready = 1'b1;
  assign alloc_o = create;
  assign done_o  = (state_q == tgen_done);

  addr_in_window_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_port.req_valid |-> (core_port.req_addr[byte_offset-1:0] == '0) &&
      ((core_port.req_addr & ~tcdm_offset_mask) == tcdm_base));

endmodule

`default_nettype wire
